// ==== build.sh ====
#!/bin/sh
# Compile the fetch front end with Verilator, run it, and check the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module fetch_tb \
    -f verilog.f \
    -Mdir obj_dir \
    -o fetch_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

// ==== logic/branch_decode.sv ====
`default_nettype none

module branch_decode (
    input  fetch_pkg::if_id_t             if_id,
    input  logic [isa_pkg::word_bits-1:0] reg_a,
    output fetch_pkg::redirect_t          redirect
);

    isa_pkg::instr_t                  fields;
    logic [isa_pkg::imm_bits-1:0]     imm16;
    logic [isa_pkg::index_bits-1:0]   index26;
    logic [isa_pkg::word_bits-1:0]    imm_offset;
    logic                             operand_zero;
    logic                             is_special;
    logic                             is_j;
    logic                             is_beqz;
    logic                             is_jr;
    logic                             is_trap;

    assign fields = if_id.instr;

    // I-type and J-type views taken from the low fields.
    assign imm16 = {fields.rd, fields.shamt, fields.funct};
    assign index26 = {fields.rs, fields.rt, fields.rd, fields.shamt, fields.funct};

    // sign extend and convert the word offset to bytes.
    assign imm_offset = {{(isa_pkg::word_bits - isa_pkg::imm_bits - 2){imm16[isa_pkg::imm_bits-1]}},
                         imm16, 2'b00};

    assign operand_zero = (reg_a == '0);

    assign is_special = (fields.opcode == isa_pkg::op_special);
    assign is_j = (fields.opcode == isa_pkg::op_j);
    assign is_beqz = (fields.opcode == isa_pkg::op_beqz) && operand_zero;
    assign is_jr = is_special && (fields.funct == isa_pkg::funct_jr);
    assign is_trap = is_special && (fields.funct == isa_pkg::funct_trap);

    assign redirect.imm_target = if_id.pc_plus4 + imm_offset;
    assign redirect.reg_target = reg_a;
    assign redirect.index_target = {if_id.pc_plus4[31:28], index26, 2'b00};

    always_comb begin
        redirect.take = 1'b1;
        if (is_j) begin
            redirect.source = fetch_pkg::src_index;
        end else if (is_beqz) begin
            redirect.source = fetch_pkg::src_imm;
        end else if (is_jr) begin
            redirect.source = fetch_pkg::src_reg;
        end else if (is_trap) begin
            redirect.source = fetch_pkg::src_trap;
        end else begin
            redirect.take = 1'b0;    // nop and everything else fall through.
            redirect.source = fetch_pkg::src_imm;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int imem_addr_bits = 7;
    localparam int imem_depth = 128;

    localparam logic [isa_pkg::word_bits-1:0] reset_pc = 32'h0000_0000;
    localparam logic [isa_pkg::word_bits-1:0] trap_vector = 32'h0000_0040;

    typedef enum logic [1:0] {
        src_imm = 2'd0,
        src_reg = 2'd1,
        src_index = 2'd2,
        src_trap = 2'd3
    } pc_source_e;

    typedef struct packed {
        logic [isa_pkg::word_bits-1:0] pc_plus4;
        logic [isa_pkg::word_bits-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                          take;
        pc_source_e                    source;
        logic [isa_pkg::word_bits-1:0] imm_target;
        logic [isa_pkg::word_bits-1:0] reg_target;
        logic [isa_pkg::word_bits-1:0] index_target;
    } redirect_t;

    typedef struct packed {
        logic                          valid;
        logic [imem_addr_bits-1:0]     addr;
        logic [isa_pkg::word_bits-1:0] word;
    } imem_load_t;

endpackage

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 issue_stall,
    input  logic                                 execute_stall,
    input  fetch_pkg::redirect_t                 redirect,
    input  logic [isa_pkg::word_bits-1:0]        read_word,
    output logic [fetch_pkg::imem_addr_bits-1:0] read_addr,
    output fetch_pkg::if_id_t                    if_id
);

    logic [isa_pkg::word_bits-1:0] pc;
    logic [isa_pkg::word_bits-1:0] pc_plus4;
    logic [isa_pkg::word_bits-1:0] redirect_target;
    logic [isa_pkg::word_bits-1:0] next_pc;

    assign read_addr = pc[fetch_pkg::imem_addr_bits+1:2];    // word index into the RAM.
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (redirect.source)
            fetch_pkg::src_imm: begin
                redirect_target = redirect.imm_target;
            end
            fetch_pkg::src_reg: begin
                redirect_target = redirect.reg_target;
            end
            fetch_pkg::src_index: begin
                redirect_target = redirect.index_target;
            end
            default: begin
                redirect_target = fetch_pkg::trap_vector;
            end
        endcase
    end

    // The word fetched alongside a redirect is the delay slot.
    assign next_pc = redirect.take ? redirect_target : pc_plus4;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc <= fetch_pkg::reset_pc;
            if_id <= '0;
        end else if (execute_stall) begin
            if_id.instr <= isa_pkg::nop_word;    // a bubble enters while pc and pc_plus4 hold.
        end else if (!issue_stall) begin
            if_id.instr <= read_word;
            if_id.pc_plus4 <= pc_plus4;
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
`default_nettype none

module fetch_top (
    input  logic                          clock,
    input  logic                          reset,
    input  fetch_pkg::imem_load_t         load,
    input  logic                          issue_stall,
    input  logic                          execute_stall,
    input  logic [isa_pkg::word_bits-1:0] reg_a,
    output fetch_pkg::if_id_t             if_id
);

    logic [fetch_pkg::imem_addr_bits-1:0] read_addr;
    logic [isa_pkg::word_bits-1:0]        read_word;
    fetch_pkg::redirect_t                 redirect;

    instr_ram instr_ram_i (
        .clock     (clock),
        .load      (load),
        .read_addr (read_addr),
        .read_word (read_word)
    );

    fetch_stage fetch_stage_i (
        .clock         (clock),
        .reset         (reset),
        .issue_stall   (issue_stall),
        .execute_stall (execute_stall),
        .redirect      (redirect),
        .read_word     (read_word),
        .read_addr     (read_addr),
        .if_id         (if_id)
    );

    // decode looks only at the registered instruction and the operand.
    branch_decode branch_decode_i (
        .if_id    (if_id),
        .reg_a    (reg_a),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

// ==== logic/instr_ram.sv ====
`default_nettype none

module instr_ram (
    input  logic                                clock,
    input  fetch_pkg::imem_load_t               load,
    input  logic [fetch_pkg::imem_addr_bits-1:0] read_addr,
    output logic [isa_pkg::word_bits-1:0]       read_word
);

    logic [isa_pkg::word_bits-1:0] mem [fetch_pkg::imem_depth];

    // Program loading goes through this single write port.
    always_ff @(posedge clock) begin
        if (load.valid) begin
            mem[load.addr] <= load.word;
        end
    end

    // Fetch sees the addressed word in the same cycle.
    assign read_word = mem[read_addr];

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int word_bits = 32;
    localparam int opcode_bits = 6;
    localparam int reg_bits = 5;
    localparam int funct_bits = 6;

    // Immediate and jump index overlay the low fields of the word.
    localparam int imm_bits = 16;
    localparam int index_bits = 26;

    typedef struct packed {
        logic [opcode_bits-1:0] opcode;
        logic [reg_bits-1:0]    rs;
        logic [reg_bits-1:0]    rt;
        logic [reg_bits-1:0]    rd;
        logic [reg_bits-1:0]    shamt;
        logic [funct_bits-1:0]  funct;
    } instr_t;

    localparam logic [opcode_bits-1:0] op_special = 6'd0;
    localparam logic [opcode_bits-1:0] op_j = 6'd2;
    localparam logic [opcode_bits-1:0] op_beqz = 6'd4;

    localparam logic [funct_bits-1:0] funct_jr = 6'd8;
    localparam logic [funct_bits-1:0] funct_trap = 6'd12;

    localparam logic [word_bits-1:0] nop_word = '0;    // all zero word doubles as the bubble.

endpackage

`default_nettype wire

// ==== test/fetch_tb.sv ====
`default_nettype none

module fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 10;
    localparam int clock_period = 2 * half_period;
    localparam int reset_cycles = 16;
    localparam int stim_cycles = 400;
    localparam int watchdog_cycles = reset_cycles + stim_cycles + 50;
    localparam int program_words = 16;

    // known flow points of the program.
    localparam logic [31:0] taken_beqz_next = 32'h0000_0024;
    localparam logic [31:0] jr_target = 32'h0000_0050;

    logic                          clock;
    logic                          reset;
    fetch_pkg::imem_load_t         load;
    logic                          issue_stall;
    logic                          execute_stall;
    logic [isa_pkg::word_bits-1:0] reg_a;
    fetch_pkg::if_id_t             if_id;

    logic [isa_pkg::word_bits-1:0]        prog [fetch_pkg::imem_depth];
    logic [fetch_pkg::imem_addr_bits-1:0] load_addr [program_words];
    logic [isa_pkg::word_bits-1:0]        load_word [program_words];

    logic [31:0]       rnd_state;
    logic [31:0]       model_pc;
    logic [32:0]       model_redirect;
    fetch_pkg::if_id_t exp_if_id;

    fetch_top dut_i (
        .clock         (clock),
        .reset         (reset),
        .load          (load),
        .issue_stall   (issue_stall),
        .execute_stall (execute_stall),
        .reg_a         (reg_a),
        .if_id         (if_id)
    );

    initial clock = 1'b0;
    always #(half_period) clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic is_control(input logic [31:0] instr);
        logic [5:0] opcode;
        logic [5:0] funct;
        opcode = instr[31:26];
        funct = instr[5:0];
        if (opcode == isa_pkg::op_j || opcode == isa_pkg::op_beqz) begin
            return 1'b1;
        end
        return (opcode == isa_pkg::op_special) &&
               (funct == isa_pkg::funct_jr || funct == isa_pkg::funct_trap);
    endfunction

    // returns {take, target} for the word held in the fetch/decode register.
    function automatic logic [32:0] predict_redirect(input fetch_pkg::if_id_t held,
                                                     input logic [31:0] operand);
        logic [5:0]  opcode;
        logic [5:0]  funct;
        logic [15:0] imm;
        logic [25:0] index;
        opcode = held.instr[31:26];
        funct = held.instr[5:0];
        imm = held.instr[15:0];
        index = held.instr[25:0];
        if (opcode == isa_pkg::op_j) begin
            return {1'b1, held.pc_plus4[31:28], index, 2'b00};
        end else if (opcode == isa_pkg::op_beqz && operand == 32'd0) begin
            return {1'b1, held.pc_plus4 + {{14{imm[15]}}, imm, 2'b00}};
        end else if (opcode == isa_pkg::op_special && funct == isa_pkg::funct_jr) begin
            return {1'b1, operand};
        end else if (opcode == isa_pkg::op_special && funct == isa_pkg::funct_trap) begin
            return {1'b1, fetch_pkg::trap_vector};
        end
        return {1'b0, 32'd0};
    endfunction

    task automatic place_word(input int slot, input logic [6:0] addr, input logic [31:0] word);
        load_addr[slot] = addr;
        load_word[slot] = word;
        prog[addr] = word;
    endtask

    // only the addresses that the flow can reach are loaded.
    task automatic build_program();
        place_word(0, 7'd0, 32'h0000_0000);
        place_word(1, 7'd1, 32'h2001_0005);
        place_word(2, 7'd2, 32'h0800_0008);     // j to word 8.
        place_word(3, 7'd3, 32'h0022_1820);
        place_word(4, 7'd8, 32'h1020_0003);     // beqz taken, lands on word 12.
        place_word(5, 7'd9, 32'h2002_0007);
        place_word(6, 7'd12, 32'h1020_fffb);    // beqz that falls through.
        place_word(7, 7'd13, 32'h0000_0000);
        place_word(8, 7'd14, 32'h0060_0008);    // jr to word 20.
        place_word(9, 7'd15, 32'h2003_0001);
        place_word(10, 7'd16, 32'h0043_2020);
        place_word(11, 7'd17, 32'h0000_0000);
        place_word(12, 7'd18, 32'h2004_0002);
        place_word(13, 7'd19, 32'h0085_2820);
        place_word(14, 7'd20, 32'h0000_000c);   // trap, back to the vector.
        place_word(15, 7'd21, 32'h2005_0003);
    endtask

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // stalls are random and the operand is steered by the word in if_id.
    task automatic drive_cycle();
        logic [31:0] rnd;
        logic [5:0]  opcode;
        logic [5:0]  funct;
        rnd_state = xorshift(rnd_state);
        rnd = rnd_state;
        opcode = exp_if_id.instr[31:26];
        funct = exp_if_id.instr[5:0];
        issue_stall = (rnd[5:4] == 2'b00);
        execute_stall = (rnd[10:8] == 3'b000) && !is_control(exp_if_id.instr);
        reg_a = rnd;
        if (opcode == isa_pkg::op_beqz) begin
            reg_a = (exp_if_id.pc_plus4 == taken_beqz_next) ? 32'd0 : (rnd | 32'd1);
        end else if (opcode == isa_pkg::op_special && funct == isa_pkg::funct_jr) begin
            reg_a = jr_target;
        end
    endtask

    assign model_redirect = predict_redirect(exp_if_id, reg_a);

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            model_pc <= fetch_pkg::reset_pc;
            exp_if_id <= '0;
        end else if (execute_stall) begin
            exp_if_id.instr <= isa_pkg::nop_word;
        end else if (!issue_stall) begin
            exp_if_id.instr <= prog[model_pc[8:2]];
            exp_if_id.pc_plus4 <= model_pc + 32'd4;
            if (model_redirect[32]) begin
                model_pc <= model_redirect[31:0];
            end else begin
                model_pc <= model_pc + 32'd4;
            end
        end
    end

    instr_matches: assert property (@(posedge clock) disable iff (!reset)
        if_id.instr === exp_if_id.instr)
    else begin
        $display("Mismatch if_id.instr: expected %h, got %h",
                 $sampled(exp_if_id.instr), $sampled(if_id.instr));
        stop_with_failure();
    end

    pc_plus4_matches: assert property (@(posedge clock) disable iff (!reset)
        if_id.pc_plus4 === exp_if_id.pc_plus4)
    else begin
        $display("Mismatch if_id.pc_plus4: expected %h, got %h",
                 $sampled(exp_if_id.pc_plus4), $sampled(if_id.pc_plus4));
        stop_with_failure();
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        stop_with_failure();
    end

    initial begin
        rnd_state = 32'd15;
        reset = 1'b0;
        issue_stall = 1'b0;
        execute_stall = 1'b0;
        reg_a = '0;
        load = '0;
        build_program();
        // one program word per reset cycle.
        for (int i = 0; i < program_words; i++) begin
            load.valid = 1'b1;
            load.addr = load_addr[i];
            load.word = load_word[i];
            @(posedge clock);
            #2;
        end
        load = '0;
        reset = 1'b1;
        reset_state: assert (if_id === '0)
        else begin
            $display("Mismatch if_id after reset: expected %h, got %h", 64'h0, if_id);
            stop_with_failure();
        end
        for (int c = 0; c < stim_cycles; c++) begin
            drive_cycle();
            @(posedge clock);
            #2;
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/isa_pkg.sv
logic/fetch_pkg.sv
logic/instr_ram.sv
logic/fetch_stage.sv
logic/branch_decode.sv
logic/fetch_top.sv
test/fetch_tb.sv
